// File: logic/tart_pkg.sv
package tart_pkg;

   // ----------------------------------------------------------------------
   // Sizes
   // ----------------------------------------------------------------------
   localparam int ANT_WIDTH     = 24;   // Antenna bits per sample
   localparam int BB_DEPTH      = 512;  // Ring buffer words
   localparam int BB_ADDR_W     = 9;
   localparam int CAPTURE_DEPTH = 256;  // Samples per acquisition
   localparam int STORE_ADDR_W  = 8;
   localparam int STORE_DATA_W  = 32;   // Top byte always zero
   localparam int SAMPLE_DIV    = 6;    // fpga_clk cycles per sample

   // ----------------------------------------------------------------------
   // Encodings
   // ----------------------------------------------------------------------
   // Scheduler state, shows up in the status byte
   typedef enum logic [2:0] {
      ST_IDLE    = 3'd0,
      ST_ACQUIRE = 3'd1,
      ST_DRAIN   = 3'd2,
      ST_READOUT = 3'd3
   } tart_state_e;

   // SPI register map
   typedef enum logic [3:0] {
      REG_STATUS  = 4'd0,
      REG_CONTROL = 4'd1,
      REG_DELAY   = 4'd2,
      REG_DATA0   = 4'd4,  // Sample bits 23:16
      REG_DATA1   = 4'd5,
      REG_DATA2   = 4'd6   // Read here requests the next word
   } reg_addr_e;

endpackage

// File: logic/mem_cmd_if.sv
`timescale 1ns/1ps

interface mem_cmd_if;
   import tart_pkg::*;

   logic                    cmd_ready;       // Store can take a command
   logic                    cmd_enable;      // Held until accepted
   logic                    cmd_wr;          // 1 write, 0 read
   logic [STORE_ADDR_W-1:0] cmd_address;
   logic [STORE_DATA_W-1:0] cmd_data_in;
   logic [STORE_DATA_W-1:0] data_out;        // Read word
   logic                    data_out_ready;  // Pulse, 2 cycles after read accept

   modport scheduler (
      input  cmd_ready, data_out_ready,
      output cmd_enable, cmd_wr, cmd_address, cmd_data_in
   );

   modport store (
      input  cmd_enable, cmd_wr, cmd_address, cmd_data_in,
      output cmd_ready, data_out, data_out_ready
   );

endinterface

// File: logic/sample_clock_delay.sv
`timescale 1ns/1ps

module sample_clock_delay
(
   input  logic       fpga_clk,
   input  logic       arst_n,
   input  logic       soft_rst,
   input  logic [2:0] sample_delay,     // Strobe phase 0..5
   output logic       sample_stb,       // One cycle in every six
   output logic       rx_clk_test_pin   // Sample clock made visible
);
   import tart_pkg::*;

   logic [2:0] phase;    // Modulo-6 count
   logic [2:0] delay_c;  // 6 and 7 behave as 5
   logic [2:0] offset;   // Counts since the strobe

   assign delay_c = (sample_delay > 3'(SAMPLE_DIV - 1)) ? 3'(SAMPLE_DIV - 1) : sample_delay;

   // Distance from strobe phase, wraps at six
   assign offset = (phase >= delay_c) ? phase - delay_c
                                      : phase + 3'(SAMPLE_DIV) - delay_c;

   assign sample_stb      = (phase == delay_c);
   assign rx_clk_test_pin = (offset < 3'(SAMPLE_DIV / 2));  // High half the period

   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
         phase <= '0;
      else if (soft_rst || phase == 3'(SAMPLE_DIV - 1))
         phase <= '0;
      else
         phase <= phase + 3'd1;
   end

endmodule

// File: logic/antenna_capture.sv
`timescale 1ns/1ps

module antenna_capture
(
   input  logic                           fpga_clk,
   input  logic                           arst_n,
   input  logic                           soft_rst,
   input  logic [tart_pkg::ANT_WIDTH-1:0] antenna,     // Receiver pins
   input  logic                           fake_en,     // Counter instead of pins
   input  logic                           sample_stb,
   input  logic [tart_pkg::BB_ADDR_W-1:0] wr_address,
   input  logic [tart_pkg::BB_ADDR_W-1:0] rd_address,
   output logic [tart_pkg::ANT_WIDTH-1:0] rd_data      // One cycle after address
);
   import tart_pkg::*;

   logic [ANT_WIDTH-1:0] real_antenna;
   logic [ANT_WIDTH-1:0] fake_antenna;
   logic [ANT_WIDTH-1:0] sel_antenna;
   logic [ANT_WIDTH-1:0] ring [BB_DEPTH];

   // ----------------------------------------------------------------------
   // Sources
   // ----------------------------------------------------------------------
   always_ff @(posedge fpga_clk)
      real_antenna <= antenna;  // IO register

   // Debug source, one count per sample
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
         fake_antenna <= '0;
      else if (soft_rst)
         fake_antenna <= '0;
      else if (sample_stb)
         fake_antenna <= fake_antenna + 1'b1;
   end

   assign sel_antenna = fake_en ? fake_antenna : real_antenna;

   // ----------------------------------------------------------------------
   // Ring buffer
   // ----------------------------------------------------------------------
   always_ff @(posedge fpga_clk)
   begin
      if (sample_stb)
         ring[wr_address] <= sel_antenna;  // Pre-increment counter value
      rd_data <= ring[rd_address];
   end

endmodule

// File: logic/capture_scheduler.sv
`timescale 1ns/1ps

module capture_scheduler
(
   input  logic                           fpga_clk,
   input  logic                           arst_n,
   input  logic                           soft_rst,
   input  logic                           sample_stb,
   input  logic                           start_aq,       // Level from control reg
   input  logic                           data_request,   // Host wants next word
   output logic [tart_pkg::BB_ADDR_W-1:0] bb_wr_address,
   output logic [tart_pkg::BB_ADDR_W-1:0] bb_rd_address,
   input  logic [tart_pkg::ANT_WIDTH-1:0] bb_rd_data,
   mem_cmd_if.scheduler                   mem,
   output tart_pkg::tart_state_e          tart_state
);
   import tart_pkg::*;

   logic [BB_ADDR_W-1:0]  wr_ptr;
   logic [BB_ADDR_W-1:0]  rd_ptr;       // Trails wr_ptr during capture
   logic                  fetch_pend;   // Ring read in flight
   logic [STORE_ADDR_W-1:0] issue_cnt;  // Store writes issued
   logic [STORE_ADDR_W:0] read_addr;    // Next readout word
   logic [STORE_ADDR_W:0] deliver_cnt;  // Words returned so far
   logic                  accept;

   assign bb_wr_address = wr_ptr;
   assign bb_rd_address = rd_ptr;
   assign accept        = mem.cmd_enable & mem.cmd_ready;

   // Write data straight from the ring read port
   always_ff @(posedge fpga_clk)
   begin
      if (tart_state == ST_ACQUIRE && fetch_pend)
         mem.cmd_data_in <= {{(STORE_DATA_W - ANT_WIDTH){1'b0}}, bb_rd_data};
   end

   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tart_state      <= ST_IDLE;
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         fetch_pend      <= 1'b0;
         issue_cnt       <= '0;
         read_addr       <= '0;
         deliver_cnt     <= '0;
         mem.cmd_enable  <= 1'b0;
         mem.cmd_wr      <= 1'b0;
         mem.cmd_address <= '0;
      end
      else if (soft_rst)
      begin
         tart_state      <= ST_IDLE;
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         fetch_pend      <= 1'b0;
         issue_cnt       <= '0;
         read_addr       <= '0;
         deliver_cnt     <= '0;
         mem.cmd_enable  <= 1'b0;
         mem.cmd_wr      <= 1'b0;
         mem.cmd_address <= '0;
      end
      else
      begin
         if (sample_stb)
            wr_ptr <= wr_ptr + 1'b1;  // Ring always fills
         if (accept)
            mem.cmd_enable <= 1'b0;   // Overridden below for back-to-back

         case (tart_state)
            ST_IDLE:
            begin
               rd_ptr    <= wr_ptr;  // Skip stale words
               issue_cnt <= '0;
               if (start_aq)
                  tart_state <= ST_ACQUIRE;
            end
            ST_ACQUIRE:
            begin
               if (fetch_pend)
               begin
                  // Ring word is on bb_rd_data now
                  fetch_pend      <= 1'b0;
                  mem.cmd_enable  <= 1'b1;
                  mem.cmd_wr      <= 1'b1;
                  mem.cmd_address <= issue_cnt;
                  rd_ptr          <= rd_ptr + 1'b1;
                  issue_cnt       <= issue_cnt + 1'b1;
                  if (issue_cnt == STORE_ADDR_W'(CAPTURE_DEPTH - 1))
                     tart_state <= ST_DRAIN;
               end
               else if (!mem.cmd_enable && rd_ptr != wr_ptr)
                  fetch_pend <= 1'b1;
            end
            ST_DRAIN:
            begin
               if (accept)
               begin
                  tart_state      <= ST_READOUT;
                  mem.cmd_enable  <= 1'b1;  // Preload word 0
                  mem.cmd_wr      <= 1'b0;
                  mem.cmd_address <= '0;
                  read_addr       <= 1;
                  deliver_cnt     <= '0;
               end
            end
            default:
            begin
               // ST_READOUT
               if (mem.data_out_ready)
                  deliver_cnt <= deliver_cnt + 1'b1;
               if (data_request && read_addr < (STORE_ADDR_W + 1)'(CAPTURE_DEPTH))
               begin
                  mem.cmd_enable  <= 1'b1;
                  mem.cmd_wr      <= 1'b0;
                  mem.cmd_address <= read_addr[STORE_ADDR_W-1:0];
                  read_addr       <= read_addr + 1'b1;
               end
               if (deliver_cnt == (STORE_ADDR_W + 1)'(CAPTURE_DEPTH) && !start_aq)
                  tart_state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: logic/sample_store.sv
`timescale 1ns/1ps

module sample_store
(
   input  logic fpga_clk,
   input  logic arst_n,
   mem_cmd_if.store mem
);
   import tart_pkg::*;

   logic [STORE_DATA_W-1:0] ram [CAPTURE_DEPTH];
   logic [STORE_DATA_W-1:0] rd_word;  // Read stage 1
   logic [1:0]              rd_pipe;  // Read-valid shift
   logic                    accept;

   assign accept             = mem.cmd_enable & mem.cmd_ready;
   assign mem.data_out_ready = rd_pipe[1];

   // ----------------------------------------------------------------------
   // Handshake and read-valid pipeline
   // ----------------------------------------------------------------------
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         mem.cmd_ready <= 1'b1;
         rd_pipe       <= '0;
      end
      else
      begin
         mem.cmd_ready <= ~accept;                      // One idle cycle per command
         rd_pipe       <= {rd_pipe[0], accept & ~mem.cmd_wr};
      end
   end

   // ----------------------------------------------------------------------
   // Memory, two register stages on the read side
   // ----------------------------------------------------------------------
   always_ff @(posedge fpga_clk)
   begin
      if (accept && mem.cmd_wr)
         ram[mem.cmd_address] <= mem.cmd_data_in;
      rd_word      <= ram[mem.cmd_address];  // Address still held on accept
      mem.data_out <= rd_word;
   end

endmodule

// File: logic/spi_target.sv
`timescale 1ns/1ps

module spi_target
(
   input  logic       fpga_clk,
   input  logic       arst_n,
   input  logic       spi_sck,
   input  logic       spi_ssel,      // Active low
   input  logic       spi_mosi,
   output logic       spi_miso,
   output logic       byte_stb,      // One pulse per received byte
   output logic       byte_is_addr,  // First byte of the frame
   output logic [7:0] rx_byte,
   input  logic [7:0] tx_byte        // Byte for the next slot
);

   logic [2:0] sck_s;     // Synchronizer plus edge history
   logic [1:0] ssel_s;
   logic [1:0] mosi_s;
   logic       sck_rise;
   logic       sck_fall;
   logic       active;
   logic [2:0] bit_cnt;
   logic [6:0] rx_shift;
   logic [7:0] tx_shift;
   logic       first;     // Address byte still to come

   assign sck_rise = sck_s[1] & ~sck_s[2];
   assign sck_fall = ~sck_s[1] & sck_s[2];
   assign active   = ~ssel_s[1];

   // Between bytes the MSB follows tx_byte so late register updates still land
   assign spi_miso = ~first & ((bit_cnt == 3'd0) ? tx_byte[7] : tx_shift[7]);

   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sck_s  <= '0;
         ssel_s <= '1;
         mosi_s <= '0;
      end
      else
      begin
         sck_s  <= {sck_s[1:0], spi_sck};
         ssel_s <= {ssel_s[0], spi_ssel};
         mosi_s <= {mosi_s[0], spi_mosi};
      end
   end

   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         bit_cnt      <= '0;
         rx_shift     <= '0;
         tx_shift     <= '0;
         first        <= 1'b1;
         byte_stb     <= 1'b0;
         byte_is_addr <= 1'b0;
         rx_byte      <= '0;
      end
      else
      begin
         byte_stb <= 1'b0;
         if (!active)
         begin
            bit_cnt <= '0;   // Frame ends, realign
            first   <= 1'b1;
         end
         else if (sck_rise)
         begin
            rx_shift <= {rx_shift[5:0], mosi_s[1]};
            bit_cnt  <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd0)
               tx_shift <= tx_byte;  // Freeze outgoing byte
            if (bit_cnt == 3'd7)
            begin
               byte_stb     <= 1'b1;
               byte_is_addr <= first;
               rx_byte      <= {rx_shift, mosi_s[1]};
               first        <= 1'b0;
            end
         end
         else if (sck_fall && bit_cnt != 3'd0)
            tx_shift <= {tx_shift[6:0], 1'b0};  // Next bit out, MSB first
      end
   end

endmodule

// File: logic/tart_regs.sv
`timescale 1ns/1ps

module tart_regs
(
   input  logic                              fpga_clk,
   input  logic                              arst_n,
   input  logic                              byte_stb,
   input  logic                              byte_is_addr,
   input  logic [7:0]                        rx_byte,
   output logic [7:0]                        tx_byte,
   input  tart_pkg::tart_state_e             tart_state,
   input  logic [tart_pkg::STORE_DATA_W-1:0] store_word,
   input  logic                              store_word_valid,
   output logic                              start_aq,
   output logic                              fake_en,
   output logic [2:0]                        sample_delay,
   output logic                              data_request,
   output logic                              soft_rst
);
   import tart_pkg::*;

   reg_addr_e            addr;         // Current register
   logic                 wr_mode;      // Bit 7 of address byte
   logic                 rst_req;      // Control bit 7, self-clearing
   logic [3:0]           rst_pipe;
   logic [ANT_WIDTH-1:0] sample_hold;  // Last word from the store

   // ----------------------------------------------------------------------
   // Read mux
   // ----------------------------------------------------------------------
   always_comb
   begin
      case (addr)
         REG_STATUS:  tx_byte = {1'b1, fake_en, data_request, start_aq, 1'b0, tart_state};
         REG_CONTROL: tx_byte = {rst_req, 5'b0, fake_en, start_aq};
         REG_DELAY:   tx_byte = {5'b0, sample_delay};
         REG_DATA0:   tx_byte = sample_hold[23:16];
         REG_DATA1:   tx_byte = sample_hold[15:8];
         REG_DATA2:   tx_byte = sample_hold[7:0];
         default:     tx_byte = 8'h00;
      endcase
   end

   always_ff @(posedge fpga_clk)
   begin
      if (store_word_valid)
         sample_hold <= store_word[ANT_WIDTH-1:0];
   end

   // ----------------------------------------------------------------------
   // Writes and address stepping
   // ----------------------------------------------------------------------
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         addr <= REG_STATUS;
         wr_mode <= 1'b0;
         rst_req <= 1'b0;
         start_aq <= 1'b0;
         fake_en <= 1'b0;
         sample_delay <= '0;
         data_request <= 1'b0;
      end
      else if (soft_rst)
      begin
         addr <= REG_STATUS;
         wr_mode <= 1'b0;
         rst_req <= 1'b0;
         start_aq <= 1'b0;
         fake_en <= 1'b0;
         sample_delay <= '0;
         data_request <= 1'b0;
      end
      else
      begin
         data_request <= 1'b0;
         rst_req      <= 1'b0;  // Single pulse into the pipe
         if (byte_stb && byte_is_addr)
         begin
            addr    <= reg_addr_e'(rx_byte[3:0]);
            wr_mode <= rx_byte[7];
         end
         else if (byte_stb)
         begin
            if (wr_mode && addr == REG_CONTROL)
            begin
               start_aq <= rx_byte[0];
               fake_en  <= rx_byte[1];
               rst_req  <= rx_byte[7];
            end
            if (wr_mode && addr == REG_DELAY)
               sample_delay <= rx_byte[2:0];
            case (addr)  // Data registers wrap 6 back to 4
               REG_DATA0: addr <= REG_DATA1;
               REG_DATA1: addr <= REG_DATA2;
               REG_DATA2:
               begin
                  addr         <= REG_DATA0;
                  data_request <= ~wr_mode;
               end
               default: addr <= addr;
            endcase
         end
      end
   end

   // Soft reset, three cycles delay then three cycles wide
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rst_pipe <= '0;
         soft_rst <= 1'b0;
      end
      else
      begin
         rst_pipe <= {rst_pipe[2:0], rst_req};
         soft_rst <= |rst_pipe[3:1];
      end
   end

endmodule

// File: logic/tart_top.sv
`timescale 1ns/1ps

module tart_top
(
   input  logic                           fpga_clk,
   input  logic                           arst_n,
   input  logic [tart_pkg::ANT_WIDTH-1:0] antenna,          // Radio data pins
   input  logic                           spi_sck,
   input  logic                           spi_ssel,
   input  logic                           spi_mosi,
   output logic                           spi_miso,
   output logic                           rx_clk_test_pin   // Delayed sample clock
);
   import tart_pkg::*;

   logic                 soft_rst;
   logic                 sample_stb;
   logic [2:0]           sample_delay;
   logic                 start_aq;
   logic                 fake_en;
   logic                 data_request;
   tart_state_e          tart_state;
   logic [BB_ADDR_W-1:0] bb_wr_address;
   logic [BB_ADDR_W-1:0] bb_rd_address;
   logic [ANT_WIDTH-1:0] bb_rd_data;
   logic                 byte_stb;
   logic                 byte_is_addr;
   logic [7:0]           rx_byte;
   logic [7:0]           tx_byte;

   mem_cmd_if mem_bus ();

   // ----------------------------------------------------------------------
   // Capture path
   // ----------------------------------------------------------------------
   sample_clock_delay u_sample_clock_delay (
      .fpga_clk(fpga_clk), .arst_n(arst_n), .soft_rst(soft_rst),
      .sample_delay(sample_delay), .sample_stb(sample_stb),
      .rx_clk_test_pin(rx_clk_test_pin)
   );

   antenna_capture u_antenna_capture (
      .fpga_clk(fpga_clk), .arst_n(arst_n), .soft_rst(soft_rst),
      .antenna(antenna), .fake_en(fake_en), .sample_stb(sample_stb),
      .wr_address(bb_wr_address), .rd_address(bb_rd_address), .rd_data(bb_rd_data)
   );

   capture_scheduler u_capture_scheduler (
      .fpga_clk(fpga_clk), .arst_n(arst_n), .soft_rst(soft_rst),
      .sample_stb(sample_stb), .start_aq(start_aq), .data_request(data_request),
      .bb_wr_address(bb_wr_address), .bb_rd_address(bb_rd_address),
      .bb_rd_data(bb_rd_data), .mem(mem_bus), .tart_state(tart_state)
   );

   sample_store u_sample_store (.fpga_clk(fpga_clk), .arst_n(arst_n), .mem(mem_bus));

   // ----------------------------------------------------------------------
   // Host side
   // ----------------------------------------------------------------------
   spi_target u_spi_target (
      .fpga_clk(fpga_clk), .arst_n(arst_n), .spi_sck(spi_sck), .spi_ssel(spi_ssel),
      .spi_mosi(spi_mosi), .spi_miso(spi_miso), .byte_stb(byte_stb),
      .byte_is_addr(byte_is_addr), .rx_byte(rx_byte), .tx_byte(tx_byte)
   );

   tart_regs u_tart_regs (
      .fpga_clk(fpga_clk), .arst_n(arst_n), .byte_stb(byte_stb),
      .byte_is_addr(byte_is_addr), .rx_byte(rx_byte), .tx_byte(tx_byte),
      .tart_state(tart_state), .store_word(mem_bus.data_out),
      .store_word_valid(mem_bus.data_out_ready), .start_aq(start_aq),
      .fake_en(fake_en), .sample_delay(sample_delay),
      .data_request(data_request), .soft_rst(soft_rst)
   );

endmodule

// File: tb/tb_tart.sv
`timescale 1ns/1ps

module tb_tart;
   import tart_pkg::*;

   logic                 fpga_clk;
   logic                 arst_n;
   logic [ANT_WIDTH-1:0] antenna;
   logic                 spi_sck;
   logic                 spi_ssel;
   logic                 spi_mosi;
   logic                 spi_miso;
   logic                 rx_clk_test_pin;

   logic        period_check_en;  // Gates the test pin assertions
   logic        pin_q;
   int          rise_count;
   int          error_count;
   int          errors_at_start;
   int          tests_run;
   int          tests_bad;
   string       test_name;
   logic [31:0] rng_state;
   event        abort_run;

   tart_top u_tart_top (
      .fpga_clk(fpga_clk), .arst_n(arst_n), .antenna(antenna), .spi_sck(spi_sck),
      .spi_ssel(spi_ssel), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
      .rx_clk_test_pin(rx_clk_test_pin)
   );

   initial fpga_clk = 1'b0;
   always #50 fpga_clk = ~fpga_clk;  // 100 ns period

   // ----------------------------------------------------------------------
   // Sample clock checks
   // ----------------------------------------------------------------------
   a_pin_period: assert property (@(posedge fpga_clk) disable iff (!arst_n || !period_check_en)
      $rose(rx_clk_test_pin) |-> ($past(rx_clk_test_pin, 6) && !$past(rx_clk_test_pin, 7)))
   else
   begin
      error_count++;
      $display("%s: rx_clk_test_pin did not rise 6 cycles after its last rise", test_name);
   end

   a_pin_high: assert property (@(posedge fpga_clk) disable iff (!arst_n || !period_check_en)
      $fell(rx_clk_test_pin) |-> ($past(rx_clk_test_pin, 2) && $past(rx_clk_test_pin, 3)
                                  && !$past(rx_clk_test_pin, 4)))
   else
   begin
      error_count++;
      $display("%s: rx_clk_test_pin was not high for exactly 3 cycles", test_name);
   end

   // Rises seen while checking is on
   always @(posedge fpga_clk)
   begin
      pin_q <= rx_clk_test_pin;
      if (!arst_n)
         rise_count <= 0;
      else if (period_check_en && rx_clk_test_pin && !pin_q)
         rise_count <= rise_count + 1;
   end

   initial
   begin
      @(abort_run);
      $display("tests failed");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   function automatic logic [31:0] next_random(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // One, fake_en, data_request, start_aq, zero, state
   function automatic logic [7:0] expected_status(input logic fake, input logic start,
                                                  input tart_state_e state);
      return {1'b1, fake, 1'b0, start, 1'b0, 3'(state)};
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual == expected)
      else
      begin
         error_count++;
         $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
      end
   endtask

   // Mode 0 byte, four clocks low and four high per bit
   task automatic spi_transfer(input logic [7:0] mosi_byte, output logic [7:0] miso_byte);
      for (int i = 7; i >= 0; i--)
      begin
         @(posedge fpga_clk);
         spi_sck  <= 1'b0;
         spi_mosi <= mosi_byte[i];
         repeat (3) @(posedge fpga_clk);
         @(negedge fpga_clk);
         miso_byte[i] = spi_miso;  // Just before SCK rises
         @(posedge fpga_clk);
         spi_sck <= 1'b1;
         repeat (3) @(posedge fpga_clk);
      end
      @(posedge fpga_clk);
      spi_sck <= 1'b0;
      repeat (12) @(posedge fpga_clk);  // Room for register and store updates
   endtask

   task automatic open_frame();
      @(posedge fpga_clk);
      spi_ssel <= 1'b0;
      repeat (4) @(posedge fpga_clk);
   endtask

   task automatic close_frame();
      @(posedge fpga_clk);
      spi_ssel <= 1'b1;
      repeat (8) @(posedge fpga_clk);
   endtask

   task automatic reg_write(input reg_addr_e addr, input logic [7:0] value);
      logic [7:0] ignored;
      open_frame();
      spi_transfer({4'h8, addr}, ignored);  // Write flag in bit 7
      spi_transfer(value, ignored);
      close_frame();
   endtask

   task automatic reg_read(input reg_addr_e addr, output logic [7:0] value);
      logic [7:0] ignored;
      open_frame();
      spi_transfer({4'h0, addr}, ignored);
      spi_transfer(8'h00, value);
      close_frame();
   endtask

   // DATA0..DATA2 in one frame, the last byte asks for the next word
   task automatic read_word(output logic [ANT_WIDTH-1:0] word);
      logic [7:0] ignored;
      logic [7:0] hi;
      logic [7:0] mid;
      logic [7:0] lo;
      open_frame();
      spi_transfer({4'h0, REG_DATA0}, ignored);
      spi_transfer(8'h00, hi);
      spi_transfer(8'h00, mid);
      spi_transfer(8'h00, lo);
      close_frame();
      word = {hi, mid, lo};
   endtask

   task automatic wait_for_state(input tart_state_e state, input int max_polls);
      logic [7:0] status;
      int         polls;
      polls = 0;
      reg_read(REG_STATUS, status);
      while (status[2:0] != 3'(state) && polls < max_polls)
      begin
         polls++;
         reg_read(REG_STATUS, status);
      end
      if (status[2:0] != 3'(state))
      begin
         $display("%s: timeout waiting for state %0d, status 0x%02h", test_name, state, status);
         -> abort_run;
         forever @(posedge fpga_clk);
      end
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = error_count;
   endtask

   task automatic finish_test();
      int errs;
      errs = error_count - errors_at_start;
      tests_run++;
      if (errs == 0)
         $display("test %s: ok", test_name);
      else
      begin
         tests_bad++;
         $display("test %s: %0d errors", test_name, errs);
      end
   endtask

   // ----------------------------------------------------------------------
   // Sequence
   // ----------------------------------------------------------------------
   initial
   begin : run_tests
      logic [7:0]           value;
      logic [ANT_WIDTH-1:0] word;
      logic [ANT_WIDTH-1:0] prev_word;
      logic [ANT_WIDTH-1:0] next_word;
      logic [31:0]          level;
      int                   rises_before;

      error_count     = 0;
      tests_run       = 0;
      tests_bad       = 0;
      test_name       = "reset";
      rng_state       = next_random(32'hd32b);
      period_check_en <= 1'b0;
      arst_n          <= 1'b0;
      spi_sck         <= 1'b0;
      spi_ssel        <= 1'b1;
      spi_mosi        <= 1'b0;
      antenna         <= rng_state[ANT_WIDTH-1:0];
      repeat (2) @(posedge fpga_clk);
      arst_n <= 1'b1;
      repeat (4) @(posedge fpga_clk);

      begin_test("reset_status");
      reg_read(REG_STATUS, value);
      check_value("status", 32'(expected_status(1'b0, 1'b0, ST_IDLE)), 32'(value));
      reg_read(REG_CONTROL, value);
      check_value("control", 32'h00, 32'(value));
      reg_read(REG_DELAY, value);
      check_value("delay", 32'h00, 32'(value));
      finish_test();

      begin_test("strobe_period");
      for (int d = 0; d < 6; d++)
      begin
         period_check_en <= 1'b0;  // Phase jumps while the delay changes
         reg_write(REG_DELAY, 8'(d));
         reg_read(REG_DELAY, value);
         check_value($sformatf("delay %0d readback", d), d, 32'(value));
         repeat (10) @(posedge fpga_clk);
         rises_before = rise_count;
         period_check_en <= 1'b1;
         repeat (60) @(posedge fpga_clk);
         period_check_en <= 1'b0;
         @(posedge fpga_clk);
         check_value($sformatf("rises at delay %0d", d), 10, rise_count - rises_before);
      end
      finish_test();

      begin_test("fake_capture");
      reg_write(REG_CONTROL, 8'h03);  // fake_en, start_aq
      wait_for_state(ST_READOUT, 40);
      reg_write(REG_CONTROL, 8'h02);
      prev_word = '0;
      for (int i = 0; i < CAPTURE_DEPTH; i++)
      begin
         read_word(word);
         next_word = prev_word + 24'd1;  // Wraps at 2^24
         if (i > 0)
            check_value($sformatf("word %0d", i), 32'(next_word), 32'(word));
         prev_word = word;
      end
      finish_test();

      begin_test("real_capture");
      wait_for_state(ST_IDLE, 20);
      rng_state = next_random(rng_state);
      level     = rng_state;
      antenna   <= level[ANT_WIDTH-1:0];
      reg_write(REG_CONTROL, 8'h01);
      wait_for_state(ST_READOUT, 40);
      reg_write(REG_CONTROL, 8'h00);
      for (int i = 0; i < CAPTURE_DEPTH; i++)
      begin
         read_word(word);
         check_value($sformatf("word %0d", i), 32'(level[ANT_WIDTH-1:0]), 32'(word));
      end
      finish_test();

      begin_test("return_idle");
      wait_for_state(ST_IDLE, 20);
      reg_read(REG_STATUS, value);
      check_value("status", 32'(expected_status(1'b0, 1'b0, ST_IDLE)), 32'(value));
      finish_test();

      begin_test("soft_reset");
      reg_write(REG_DELAY, 8'h03);
      reg_write(REG_CONTROL, 8'h03);
      reg_read(REG_STATUS, value);
      check_value("status before", 32'(expected_status(1'b1, 1'b1, ST_ACQUIRE)), 32'(value));
      reg_write(REG_CONTROL, 8'h83);  // Start and fake stay set, only the reset clears them
      repeat (10) @(posedge fpga_clk);  // Sync plus pulse width
      reg_read(REG_STATUS, value);
      check_value("status after", 32'(expected_status(1'b0, 1'b0, ST_IDLE)), 32'(value));
      reg_read(REG_DELAY, value);
      check_value("delay", 32'h00, 32'(value));
      reg_read(REG_CONTROL, value);
      check_value("control", 32'h00, 32'(value));
      finish_test();

      $display("%0d tests run, %0d ok, %0d with errors", tests_run, tests_run - tests_bad,
               tests_bad);
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: compile.f
logic/tart_pkg.sv
logic/mem_cmd_if.sv
logic/sample_clock_delay.sv
logic/antenna_capture.sv
logic/capture_scheduler.sv
logic/sample_store.sv
logic/spi_target.sv
logic/tart_regs.sv
logic/tart_top.sv
tb/tb_tart.sv

// File: Makefile
TB_TOP := tb_tart

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module tart_top
	verilator --lint-only --timing --assert -f compile.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir
